// ==== hw/rom_map_pkg.sv ====
// Memory map and shared types of the ROM subsystem
// Download order is main, char, obj. Bytes past ROM_END are not stored
// SDRAM addresses count 16-bit words, a read returns the even word in bits 15:0
`default_nettype none

package rom_map_pkg;

    typedef logic [21:0] sdram_addr_t;  // 16-bit word units
    typedef logic [31:0] sdram_word_t;  // Two words, even one low
    typedef logic [21:0] dl_addr_t;     // Download byte address

    // Client payloads
    typedef logic [7:0]  rom_byte_t;
    typedef logic [15:0] rom_half_t;

    // Regions in the download file, byte addresses
    localparam dl_addr_t MAIN_START = 22'h000000;
    localparam dl_addr_t CHAR_START = 22'h040000;
    localparam dl_addr_t OBJ_START  = 22'h060000;
    localparam dl_addr_t ROM_END    = 22'h160000;

    // Same regions seen from the SDRAM side
    localparam sdram_addr_t MAIN_OFFSET = MAIN_START >> 1;
    localparam sdram_addr_t CHAR_OFFSET = CHAR_START >> 1;
    localparam sdram_addr_t OBJ_OFFSET  = OBJ_START >> 1;

    localparam int MAIN_AW = 18;  // Bytes
    localparam int CHAR_AW = 17;  // Bytes
    localparam int OBJ_AW  = 19;  // Halfwords

    localparam int SLOT_COUNT = 3;
    localparam int SLOT_W     = $clog2(SLOT_COUNT);

    typedef logic [SLOT_W-1:0] slot_idx_t;

    // Lower index wins arbitration
    localparam slot_idx_t SLOT_MAIN = 0;
    localparam slot_idx_t SLOT_CHAR = 1;
    localparam slot_idx_t SLOT_OBJ  = 2;

    typedef struct packed {
        logic        req;
        sdram_addr_t word_addr;  // Always even
    } slot_req_t;

    typedef struct packed {
        logic        valid;  // One-cycle strobe
        sdram_word_t data;
    } slot_fill_t;

    typedef struct packed {
        sdram_addr_t addr;
        logic [7:0]  data;
        logic [1:0]  mask;   // Set bit leaves that byte untouched
    } prog_t;

endpackage

`default_nettype wire

// ==== hw/rom_loader.sv ====
// Turns download bytes into SDRAM programming writes and holds the game in reset
// One write in flight, a new ioctl_wr replaces a write that was not yet acked
// Only bytes below ROM_END reach the SDRAM
`timescale 1ns/100ps
`default_nettype none

module rom_loader (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  downloading,
    input  wire logic                  ioctl_wr,
    input  wire rom_map_pkg::dl_addr_t ioctl_addr,
    input  wire logic [7:0]            ioctl_data,
    input  wire logic                  sdram_ack,
    output rom_map_pkg::prog_t         prog,
    output logic                       prog_we,
    output logic                       game_reset
);

    logic in_range;
    logic reset_hold;   // First stage of the release delay

    assign in_range = ioctl_addr < rom_map_pkg::ROM_END;

    // Write strobe, held until the SDRAM takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else begin
            if (ioctl_wr && in_range) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Payload of the write
    always_ff @(posedge clk) begin
        if (ioctl_wr && in_range) begin
            prog.addr <= ioctl_addr >> 1;
            prog.data <= ioctl_data;
            // Even byte goes low, so the high byte is masked
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    // Game released two clocks after the download ends
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            reset_hold <= 1'b1;
            game_reset <= 1'b1;
        end else begin
            reset_hold <= 1'b0;
            game_reset <= reset_hold;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rom_slot_cache.sv ====
// One ROM client slot caching the last 32-bit SDRAM word it read
// payload_t must be 8 or 16 bits wide, sub-word picked little-endian
// Client keeps cs and addr stable until ok, reset flushes the cached word
`timescale 1ns/100ps
`default_nettype none

module rom_slot_cache #(
    parameter type payload_t = logic [7:0],
    parameter int  AW        = 18
) (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     cs,
    input  wire logic [AW-1:0]            addr,
    output logic                          ok,
    output payload_t                      data,
    output rom_map_pkg::slot_req_t        req,
    input  wire rom_map_pkg::slot_fill_t  fill,
    input  wire rom_map_pkg::sdram_addr_t offset
);

    localparam int PW    = $bits(payload_t);
    localparam int SEL_W = $clog2(32 / PW);   // Payloads per word, as index bits

    rom_map_pkg::sdram_word_t cached_word;
    rom_map_pkg::sdram_addr_t cached_addr;
    logic                     cached_valid;

    logic                     req_pending;
    rom_map_pkg::sdram_addr_t req_addr;

    rom_map_pkg::sdram_addr_t word_addr;
    rom_map_pkg::sdram_word_t view_word;
    rom_map_pkg::sdram_addr_t view_addr;
    logic                     view_valid;
    logic                     hit;
    logic                     start_miss;
    logic [SEL_W-1:0]         sel;

    assign sel = addr[SEL_W-1:0];

    // Even SDRAM address of the 32-bit word holding addr
    assign word_addr = offset + rom_map_pkg::sdram_addr_t'({addr[AW-1:SEL_W], 1'b0});

    // Fill word is usable in its own cycle
    assign view_word  = fill.valid ? fill.data : cached_word;
    assign view_addr  = fill.valid ? req_addr : cached_addr;
    assign view_valid = fill.valid || cached_valid;

    assign hit        = view_valid && (view_addr == word_addr);
    assign start_miss = cs && !hit && !req_pending;

    assign req = '{req: req_pending, word_addr: req_addr};

    always_ff @(posedge clk) begin
        if (reset) begin
            ok           <= 1'b0;
            req_pending  <= 1'b0;
            cached_valid <= 1'b0;
        end else begin
            ok <= cs && hit;
            if (fill.valid) begin
                cached_valid <= 1'b1;
                req_pending  <= 1'b0;
            end else if (start_miss) begin
                req_pending <= 1'b1;   // Held until the fill strobe
            end
        end
    end

    always_ff @(posedge clk) begin
        data <= payload_t'(view_word[sel*PW +: PW]);
        if (fill.valid) begin
            cached_word <= fill.data;
            cached_addr <= req_addr;
        end
        if (start_miss) begin
            req_addr <= word_addr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sdram_read_arbiter.sv ====
// Fixed-priority arbiter for slot misses on the SDRAM read port
// Slot 0 has the highest priority, one read in flight at a time
// The word comes with the first data_rdy after sdram_ack
`timescale 1ns/100ps
`default_nettype none

module sdram_read_arbiter (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire rom_map_pkg::slot_req_t   reqs  [rom_map_pkg::SLOT_COUNT],
    output rom_map_pkg::slot_fill_t       fills [rom_map_pkg::SLOT_COUNT],
    output logic                          sdram_req,
    output rom_map_pkg::sdram_addr_t      sdram_addr,
    input  wire logic                     sdram_ack,
    input  wire logic                     data_rdy,
    input  wire rom_map_pkg::sdram_word_t data_read
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,   // sdram_req up, waiting for ack
        WAIT   // Acked, waiting for data_rdy
    } state_t;

    state_t                 state;
    rom_map_pkg::slot_idx_t grant;
    rom_map_pkg::slot_idx_t pick;
    logic                   any_req;

    // Lowest requesting index
    always_comb begin
        any_req = 1'b0;
        pick    = '0;
        for (int i = rom_map_pkg::SLOT_COUNT - 1; i >= 0; i--) begin
            if (reqs[i].req) begin
                any_req = 1'b1;
                pick    = rom_map_pkg::slot_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            grant     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (any_req) begin
                        state     <= REQ;
                        sdram_req <= 1'b1;
                        grant     <= pick;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin
                        state     <= WAIT;
                        sdram_req <= 1'b0;
                    end
                end
                WAIT: begin
                    if (data_rdy) begin
                        state <= IDLE;   // Slot drops req on this edge
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address stays put until the next grant
    always_ff @(posedge clk) begin
        if (state == IDLE && any_req) begin
            sdram_addr <= reqs[pick].word_addr;
        end
    end

    // Fill goes out in the data_rdy cycle, to the granted slot only
    always_comb begin
        for (int i = 0; i < rom_map_pkg::SLOT_COUNT; i++) begin
            fills[i].valid = (state == WAIT) && data_rdy &&
                             (grant == rom_map_pkg::slot_idx_t'(i));
            fills[i].data  = data_read;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rom_system.sv ====
// ROM subsystem top: download path, game reset and three cached ROM slots
// SDRAM ack is shared, reads only run once game_reset is low
// so they never overlap a programming write
`timescale 1ns/100ps
`default_nettype none

module rom_system (
    input  wire logic                              clk,
    input  wire logic                              reset,
    // Download port
    input  wire logic                              downloading,
    input  wire rom_map_pkg::dl_addr_t             ioctl_addr,
    input  wire logic [7:0]                        ioctl_data,
    input  wire logic                              ioctl_wr,
    output rom_map_pkg::prog_t                     prog,
    output logic                                   prog_we,
    output logic                                   game_reset,
    // SDRAM read port
    output logic                                   sdram_req,
    output rom_map_pkg::sdram_addr_t               sdram_addr,
    input  wire logic                              sdram_ack,
    input  wire logic                              data_rdy,
    input  wire rom_map_pkg::sdram_word_t          data_read,
    // Main CPU code
    input  wire logic                              main_cs,
    input  wire logic [rom_map_pkg::MAIN_AW-1:0]   main_addr,
    output logic                                   main_ok,
    output logic [7:0]                             main_data,
    // Characters
    input  wire logic                              char_cs,
    input  wire logic [rom_map_pkg::CHAR_AW-1:0]   char_addr,
    output logic                                   char_ok,
    output logic [7:0]                             char_data,
    // Objects, halfword addressed
    input  wire logic                              obj_cs,
    input  wire logic [rom_map_pkg::OBJ_AW-1:0]    obj_addr,
    output logic                                   obj_ok,
    output logic [15:0]                            obj_data
);

    rom_map_pkg::slot_req_t  reqs  [rom_map_pkg::SLOT_COUNT];
    rom_map_pkg::slot_fill_t fills [rom_map_pkg::SLOT_COUNT];

    rom_loader u_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .game_reset  ( game_reset  )
    );

    rom_slot_cache #(
        .payload_t ( rom_map_pkg::rom_byte_t ),
        .AW        ( rom_map_pkg::MAIN_AW    )
    ) u_main (
        .clk    ( clk                            ),
        .reset  ( game_reset                     ),   // Flushed after each download
        .cs     ( main_cs                        ),
        .addr   ( main_addr                      ),
        .ok     ( main_ok                        ),
        .data   ( main_data                      ),
        .req    ( reqs[rom_map_pkg::SLOT_MAIN]   ),
        .fill   ( fills[rom_map_pkg::SLOT_MAIN]  ),
        .offset ( rom_map_pkg::MAIN_OFFSET       )
    );

    rom_slot_cache #(
        .payload_t ( rom_map_pkg::rom_byte_t ),
        .AW        ( rom_map_pkg::CHAR_AW    )
    ) u_char (
        .clk    ( clk                            ),
        .reset  ( game_reset                     ),
        .cs     ( char_cs                        ),
        .addr   ( char_addr                      ),
        .ok     ( char_ok                        ),
        .data   ( char_data                      ),
        .req    ( reqs[rom_map_pkg::SLOT_CHAR]   ),
        .fill   ( fills[rom_map_pkg::SLOT_CHAR]  ),
        .offset ( rom_map_pkg::CHAR_OFFSET       )
    );

    rom_slot_cache #(
        .payload_t ( rom_map_pkg::rom_half_t ),
        .AW        ( rom_map_pkg::OBJ_AW     )
    ) u_obj (
        .clk    ( clk                            ),
        .reset  ( game_reset                     ),
        .cs     ( obj_cs                         ),
        .addr   ( obj_addr                       ),
        .ok     ( obj_ok                         ),
        .data   ( obj_data                       ),
        .req    ( reqs[rom_map_pkg::SLOT_OBJ]    ),
        .fill   ( fills[rom_map_pkg::SLOT_OBJ]   ),
        .offset ( rom_map_pkg::OBJ_OFFSET        )
    );

    sdram_read_arbiter u_arbiter (
        .clk        ( clk        ),
        .reset      ( game_reset ),
        .reqs       ( reqs       ),
        .fills      ( fills      ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

endmodule

`default_nettype wire

// ==== verification/rom_system_asserts.sv ====
// Protocol checks on the SDRAM read port and the slot fill strobes
// Bound to every sdram_read_arbiter, all checks held off during reset
`timescale 1ns/100ps
`default_nettype none

module rom_system_asserts (
    input wire logic                     clk,
    input wire logic                     reset,
    input wire logic                     sdram_req,
    input wire rom_map_pkg::sdram_addr_t sdram_addr,
    input wire logic                     sdram_ack,
    input wire rom_map_pkg::slot_req_t   reqs  [rom_map_pkg::SLOT_COUNT],
    input wire rom_map_pkg::slot_fill_t  fills [rom_map_pkg::SLOT_COUNT]
);

    logic [rom_map_pkg::SLOT_COUNT-1:0] fill_vec;
    logic [rom_map_pkg::SLOT_COUNT-1:0] req_vec;
    logic                               acked;   // Ack seen, fill not yet delivered

    always_comb begin
        for (int i = 0; i < rom_map_pkg::SLOT_COUNT; i++) begin
            fill_vec[i] = fills[i].valid;
            req_vec[i]  = reqs[i].req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acked <= 1'b0;
        end else if (sdram_req && sdram_ack) begin
            acked <= 1'b1;
        end else if (|fill_vec) begin
            acked <= 1'b0;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req dropped or sdram_addr moved before sdram_ack");

    // A fill may only reach a slot that is still waiting for it
    a_one_fill: assert property (@(posedge clk) disable iff (reset)
        $onehot0(fill_vec) && ((fill_vec & ~req_vec) == '0))
        else $error("more than one fill strobe, or a fill to a slot without req");

    a_fill_after_ack: assert property (@(posedge clk) disable iff (reset)
        |fill_vec |-> acked)
        else $error("fill strobe without a preceding sdram_ack");

endmodule

bind sdram_read_arbiter rom_system_asserts u_asserts (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .sdram_req  ( sdram_req  ),
    .sdram_addr ( sdram_addr ),
    .sdram_ack  ( sdram_ack  ),
    .reqs       ( reqs       ),
    .fills      ( fills      )
);

`default_nettype wire

// ==== verification/rom_system_tb.sv ====
// Testbench for rom_system with a behavioral SDRAM answering after random delays
// Downloads a short chunk per region plus bytes past ROM_END, reads only inside the chunks
`timescale 1ns/100ps
`default_nettype none

module rom_system_tb;

    localparam int   CHUNK    = 32;
    localparam int   DL_BYTES = 3 * CHUNK + 4;
    localparam int   READS    = 32;
    localparam int   TIMEOUT  = (DL_BYTES * 8 + READS * 40 + 20) * 2;
    localparam int   MAIN_AT  = 'h01200;   // Slot addresses of the chunks
    localparam int   CHAR_AT  = 'h00a40;
    localparam int   OBJ_AT   = 'h08000;   // Halfwords
    localparam int   IMG_SIZE = int'(rom_map_pkg::ROM_END);

    logic clk = 1'b0;
    logic reset, downloading, ioctl_wr, sdram_ack, data_rdy;
    rom_map_pkg::dl_addr_t    ioctl_addr;
    logic [7:0]               ioctl_data;
    rom_map_pkg::sdram_word_t data_read;
    rom_map_pkg::prog_t       prog;
    logic                     prog_we, game_reset, sdram_req;
    rom_map_pkg::sdram_addr_t sdram_addr;
    logic                           main_cs, char_cs, obj_cs, main_ok, char_ok, obj_ok;
    logic [rom_map_pkg::MAIN_AW-1:0] main_addr;
    logic [rom_map_pkg::CHAR_AW-1:0] char_addr;
    logic [rom_map_pkg::OBJ_AW-1:0]  obj_addr;
    logic [7:0]  main_data, char_data;
    logic [15:0] obj_data;

    logic [7:0]  image     [0:IMG_SIZE-1];     // Expected ROM contents
    logic [15:0] sdram_mem [0:IMG_SIZE/2-1];
    logic [31:0] lfsr = 32'hf76c6051;
    int          cycle_count = 0;

    rom_system uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT));
        end
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return v;
    endfunction

    // Expected payload of a slot read, from the download image
    function automatic logic [15:0] ref_data(input rom_map_pkg::slot_idx_t slot, input int a);
        case (slot)
            rom_map_pkg::SLOT_MAIN: return {8'h00, image[int'(rom_map_pkg::MAIN_START) + a]};
            rom_map_pkg::SLOT_CHAR: return {8'h00, image[int'(rom_map_pkg::CHAR_START) + a]};
            default: return {image[int'(rom_map_pkg::OBJ_START) + 2 * a + 1],
                             image[int'(rom_map_pkg::OBJ_START) + 2 * a]};
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input rom_map_pkg::rom_byte_t got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("FAIL at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_half(input rom_map_pkg::rom_half_t got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("FAIL at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_prog(input rom_map_pkg::prog_t got, exp);
        if (got !== exp)
            fail_run($sformatf("FAIL at %0t: prog got %h expected %h", $time, got, exp));
    endtask

    task automatic check_level(input logic got, exp, input string what);
        if (got !== exp)
            fail_run($sformatf("FAIL at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    // SDRAM model, one access at a time
    int                       mstate = 0;   // 0 idle, 1 write ack, 2 read ack, 3 data
    int                       wait_cnt;
    rom_map_pkg::sdram_addr_t rd_addr;
    always @(posedge clk) begin
        #1;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        if (mstate == 0 && prog_we) begin
            if (!prog.mask[0]) sdram_mem[int'(prog.addr)][7:0]  = prog.data;
            if (!prog.mask[1]) sdram_mem[int'(prog.addr)][15:8] = prog.data;
            wait_cnt = int'(lfsr_bits(2));
            mstate   = 1;
        end else if (mstate == 0 && sdram_req) begin
            rd_addr  = sdram_addr;
            wait_cnt = int'(lfsr_bits(2));
            mstate   = 2;
        end
        if (mstate == 3) begin
            if (wait_cnt == 0) begin
                data_rdy  = 1'b1;
                data_read = {sdram_mem[int'(rd_addr) + 1], sdram_mem[int'(rd_addr)]};
                mstate    = 0;
            end else wait_cnt--;
        end else if (mstate != 0) begin
            if (wait_cnt == 0) begin
                sdram_ack = 1'b1;
                wait_cnt  = int'(lfsr_bits(2));   // data_rdy 1 to 4 cycles later
                mstate    = (mstate == 2) ? 3 : 0;
            end else wait_cnt--;
        end
    end

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic dl_byte(input rom_map_pkg::dl_addr_t a);
        rom_map_pkg::prog_t exp;
        logic [7:0]         d;
        d          = 8'(lfsr_bits(8));
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        step();
        ioctl_wr = 1'b0;
        if (a < rom_map_pkg::ROM_END) begin
            image[int'(a)] = d;
            // Only the byte picked by the address parity is written
            exp = '{addr: a >> 1, data: d, mask: 2'b11 & ~(2'b01 << a[0])};
            check_level(prog_we, 1'b1, "prog_we");
            check_prog(prog, exp);
            while (prog_we) step();
        end else begin
            repeat (3) begin
                check_level(prog_we, 1'b0, "prog_we past ROM_END");
                step();
            end
        end
        check_level(game_reset, 1'b1, "game_reset while downloading");
    endtask

    task automatic read_main(input int a, output int cyc);
        main_cs   = 1'b1;
        main_addr = a[rom_map_pkg::MAIN_AW-1:0];
        cyc = 0;
        do begin
            step();
            cyc++;
        end while (!main_ok);
        main_cs = 1'b0;
        check_byte(main_data, rom_map_pkg::rom_byte_t'(ref_data(rom_map_pkg::SLOT_MAIN, a)),
                   "main_data");
        step();
    endtask

    task automatic read_char(input int a, output int cyc);
        char_cs   = 1'b1;
        char_addr = a[rom_map_pkg::CHAR_AW-1:0];
        cyc = 0;
        do begin
            step();
            cyc++;
        end while (!char_ok);
        char_cs = 1'b0;
        check_byte(char_data, rom_map_pkg::rom_byte_t'(ref_data(rom_map_pkg::SLOT_CHAR, a)),
                   "char_data");
        step();
    endtask

    task automatic read_obj(input int a, output int cyc);
        obj_cs   = 1'b1;
        obj_addr = a[rom_map_pkg::OBJ_AW-1:0];
        cyc = 0;
        do begin
            step();
            cyc++;
        end while (!obj_ok);
        obj_cs = 1'b0;
        check_half(obj_data, ref_data(rom_map_pkg::SLOT_OBJ, a), "obj_data");
        step();
    endtask

    initial begin
        int ca, cb, cc, am, ac, ao;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        sdram_ack   = 1'b0;
        data_rdy    = 1'b0;
        data_read   = '0;
        main_cs     = 1'b0;
        char_cs     = 1'b0;
        obj_cs      = 1'b0;
        main_addr   = '0;
        char_addr   = '0;
        obj_addr    = '0;
        repeat (2) step();
        check_level(game_reset, 1'b1, "game_reset in reset");
        check_level(prog_we, 1'b0, "prog_we after reset");
        check_level(sdram_req, 1'b0, "sdram_req after reset");
        reset       = 1'b0;
        downloading = 1'b1;
        for (int i = 0; i < CHUNK; i++) begin
            dl_byte(rom_map_pkg::MAIN_START + rom_map_pkg::dl_addr_t'(MAIN_AT + i));
            dl_byte(rom_map_pkg::CHAR_START + rom_map_pkg::dl_addr_t'(CHAR_AT + i));
            dl_byte(rom_map_pkg::OBJ_START + rom_map_pkg::dl_addr_t'(2 * OBJ_AT + i));
        end
        for (int i = 0; i < 4; i++) dl_byte(rom_map_pkg::ROM_END + rom_map_pkg::dl_addr_t'(i));
        downloading = 1'b0;
        step();
        check_level(game_reset, 1'b1, "game_reset one cycle after download");
        step();
        check_level(game_reset, 1'b0, "game_reset two cycles after download");

        // Miss then hit on the neighbouring byte
        for (int i = 0; i < 4; i++) begin
            am = MAIN_AT + int'(lfsr_bits(5));
            read_main(am, ca);
            read_main(am ^ 1, ca);
            check_level(ca == 1, 1'b1, "main hit latency");
            ac = CHAR_AT + int'(lfsr_bits(5));
            read_char(ac, cb);
            read_char(ac ^ 1, cb);
            check_level(cb == 1, 1'b1, "char hit latency");
            read_obj(OBJ_AT + int'(lfsr_bits(4)), cc);
        end
        // All slots contend for the read port
        for (int i = 0; i < 4; i++) begin
            am = MAIN_AT + int'(lfsr_bits(5));
            ac = CHAR_AT + int'(lfsr_bits(5));
            ao = OBJ_AT + int'(lfsr_bits(4));
            fork
                read_main(am, ca);
                read_char(ac, cb);
                read_obj(ao, cc);
            join
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/rom_map_pkg.sv
hw/rom_loader.sv
hw/rom_slot_cache.sv
hw/sdram_read_arbiter.sv
hw/rom_system.sv
verification/rom_system_asserts.sv
verification/rom_system_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ROM subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module rom_system_tb \
    --Mdir obj_dir \
    -o rom_system_sim

# The log decides the result, not the simulator exit status
./obj_dir/rom_system_sim 2>&1 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
